// ==== flist.f ====
src/fetchPkg.sv
src/progCounter.sv
src/instrRom.sv
src/instrDecoder.sv
src/fetchStage.sv
testbench/fetchStageTb.sv

// ==== src/fetchPkg.sv ====
// Fetch stage shared definitions
package fetchPkg;

    localparam int wordWidth    = 16;
    localparam int regAddrWidth = 3;
    localparam int romDepth     = 256;
    localparam int romAddrWidth = $clog2(romDepth);

    localparam string romImage = "testbench/fetchProgram.hex";

    localparam logic [wordWidth-1:0]    siicVector = 16'h0002;  // Exception handler entry
    localparam logic [wordWidth-1:0]    pcStep     = 16'h0002;  // Byte step per instruction
    localparam logic [regAddrWidth-1:0] linkReg    = 3'd7;
    localparam logic [wordWidth-1:0]    nopWord    = 16'h0800;  // NOP opcode with zero operands

    // Writeback source selects
    localparam logic [1:0] linkAlu = 2'b00;  // ALU or memory result
    localparam logic [1:0] linkPc  = 2'b01;  // Return address
    localparam logic [1:0] linkImm = 2'b10;  // Immediate straight to register

    // WISC opcodes, all 32 encodings defined
    typedef enum logic [4:0] {
        HALT   = 5'b00000,
        NOP    = 5'b00001,
        SIIC   = 5'b00010,
        RTI    = 5'b00011,
        J      = 5'b00100,
        JR     = 5'b00101,
        JAL    = 5'b00110,
        JALR   = 5'b00111,
        ADDI   = 5'b01000,
        SUBI   = 5'b01001,
        XORI   = 5'b01010,
        ANDNI  = 5'b01011,
        BEQZ   = 5'b01100,
        BNEZ   = 5'b01101,
        BLTZ   = 5'b01110,
        BGEZ   = 5'b01111,
        ST     = 5'b10000,
        LD     = 5'b10001,
        SLBI   = 5'b10010,
        STU    = 5'b10011,
        ROLI   = 5'b10100,
        SLLI   = 5'b10101,
        RORI   = 5'b10110,
        SRLI   = 5'b10111,
        LBI    = 5'b11000,
        BTR    = 5'b11001,
        ROTR   = 5'b11010,  // ROL, SLL, ROR, SRL by func
        ARITHR = 5'b11011,  // ADD, SUB, XOR, ANDN by func
        SEQ    = 5'b11100,
        SLT    = 5'b11101,
        SLE    = 5'b11110,
        SCO    = 5'b11111
    } opcodeT;

    typedef struct packed {
        opcodeT                  op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [1:0]              func;
    } rFormatT;

    typedef struct packed {
        opcodeT                  op;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rd;
        logic [4:0]              imm5;
    } i1FormatT;

    typedef struct packed {
        opcodeT                  op;
        logic [regAddrWidth-1:0] rs;
        logic [7:0]              imm8;
    } i2FormatT;

    typedef struct packed {
        opcodeT      op;
        logic [10:0] disp11;
    } jFormatT;

    // One instruction word in four field layouts
    typedef union packed {
        rFormatT  rFormat;
        i1FormatT i1Format;
        i2FormatT i2Format;
        jFormatT  jFormat;
    } instrT;

    typedef enum logic [1:0] {
        fromRs  = 2'b00,
        fromRdR = 2'b01,
        fromR7  = 2'b10,
        fromRdI = 2'b11
    } destSelT;

    typedef enum logic [2:0] {
        immZext5  = 3'd0,
        immSext5  = 3'd1,
        immSext8  = 3'd2,
        immZext8  = 3'd3,
        immSext11 = 3'd4
    } immSelT;

    typedef struct packed {
        opcodeT     aluOp;
        logic       regWrite;
        logic       memEnable;
        logic       memWr;
        logic       val2Reg;   // Load data to register
        logic       aluSel;    // Immediate as second operand
        immSelT     immSel;
        logic [1:0] linkSel;
        logic       branch;    // Resolved in a later stage
        logic       regJmp;
        logic       halt;
        logic       siic;
        logic       rti;
    } ctrlT;

endpackage

// ==== src/fetchStage.sv ====
// Fetch stage top level
`timescale 1ns/1ps

module fetchStage import fetchPkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [wordWidth-1:0]    brnchAddr,
    input  logic                    pcSel,
    input  logic [wordWidth-1:0]    rs,
    input  logic [wordWidth-1:0]    imm,
    input  logic                    hazNop,
    output logic [wordWidth-1:0]    pc,
    output instrT                   instr,
    output ctrlT                    ctrl,
    output logic [regAddrWidth-1:0] writeRegAddr
);

    instrT romWord;    // Raw word before bubble injection

    progCounter progCnt (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),         // Jump, halt and exception requests
        .pcSel     (pcSel),
        .brnchAddr (brnchAddr),
        .rs        (rs),
        .imm       (imm),
        .pc        (pc)
    );

    instrRom instrMem (
        .pc        (pc),
        .instrWord (romWord)
    );

    instrDecoder decode (
        .instrWord    (romWord),
        .hazNop       (hazNop),
        .instr        (instr),
        .ctrl         (ctrl),
        .writeRegAddr (writeRegAddr)
    );

endmodule

// ==== src/instrDecoder.sv ====
// Instruction decoder
`timescale 1ns/1ps

module instrDecoder import fetchPkg::*; (
    input  instrT                   instrWord,
    input  logic                    hazNop,
    output instrT                   instr,
    output ctrlT                    ctrl,
    output logic [regAddrWidth-1:0] writeRegAddr
);

    destSelT destSel;

    // Hazard turns the fetched word into a bubble
    assign instr = hazNop ? instrT'(nopWord) : instrWord;

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = instr.rFormat.op;
        destSel    = fromRdI;
        case (instr.rFormat.op)
            HALT: ctrl.halt = 1'b1;
            NOP: ;                        // Idle slot
            SIIC: ctrl.siic = 1'b1;
            RTI: ctrl.rti = 1'b1;
            J: begin
                ctrl.branch = 1'b1;
                ctrl.immSel = immSext11;
            end
            JR: begin
                ctrl.regJmp = 1'b1;
                ctrl.aluSel = 1'b1;
                ctrl.immSel = immSext8;
            end
            JAL: begin
                ctrl.branch   = 1'b1;
                ctrl.immSel   = immSext11;
                ctrl.regWrite = 1'b1;
                ctrl.linkSel  = linkPc;
                destSel       = fromR7;
            end
            JALR: begin
                ctrl.regJmp   = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = immSext8;
                ctrl.regWrite = 1'b1;
                ctrl.linkSel  = linkPc;
                destSel       = fromR7;
            end
            ADDI, SUBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = immSext5;
            end
            // Logic and shift immediates are unsigned
            XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
            end
            BEQZ, BNEZ, BLTZ, BGEZ: begin
                ctrl.branch = 1'b1;
                ctrl.immSel = immSext8;
            end
            ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = immSext5;
            end
            LD: begin
                ctrl.memEnable = 1'b1;
                ctrl.val2Reg   = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = immSext5;
            end
            STU: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.regWrite  = 1'b1;    // Updated base back to Rs
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = immSext5;
                destSel        = fromRs;
            end
            LBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = immSext8;
                ctrl.linkSel  = linkImm;
                destSel       = fromRs;
            end
            SLBI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = immZext8;
                destSel       = fromRs;
            end
            BTR, ROTR, ARITHR, SEQ, SLT, SLE, SCO: begin
                ctrl.regWrite = 1'b1;
                destSel       = fromRdR;
            end
        endcase
    end

    // Destination index taken from the matching field layout
    always_comb begin
        case (destSel)
            fromRs:  writeRegAddr = instr.i2Format.rs;
            fromRdR: writeRegAddr = instr.rFormat.rd;
            fromR7:  writeRegAddr = linkReg;
            fromRdI: writeRegAddr = instr.i1Format.rd;
            default: writeRegAddr = instr.i1Format.rd;
        endcase
    end

endmodule

// ==== src/instrRom.sv ====
// Instruction memory
`timescale 1ns/1ps

module instrRom import fetchPkg::*; (
    input  logic [wordWidth-1:0] pc,
    output instrT                instrWord
);

    logic [wordWidth-1:0] mem [romDepth];
    logic [romAddrWidth-1:0] wordAddr;

    initial begin
        $readmemh(romImage, mem);
    end

    // Upper address bits dropped so fetch wraps
    assign wordAddr = pc[romAddrWidth:1];

    assign instrWord = instrT'(mem[wordAddr]);  // Asynchronous read

endmodule

// ==== src/progCounter.sv ====
// Program counter with exception return
`timescale 1ns/1ps

module progCounter import fetchPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  ctrlT                 ctrl,
    input  logic                 pcSel,
    input  logic [wordWidth-1:0] brnchAddr,
    input  logic [wordWidth-1:0] rs,
    input  logic [wordWidth-1:0] imm,
    output logic [wordWidth-1:0] pc
);

    logic [wordWidth-1:0] epc;
    logic [wordWidth-1:0] pcPlus2;
    logic [wordWidth-1:0] nextPc;
    logic                 saveEpc;

    assign pcPlus2 = pc + pcStep;

    // Redirect sources in priority order
    always_comb begin
        nextPc  = pcPlus2;
        saveEpc = 1'b0;
        if (pcSel) begin
            nextPc = brnchAddr;           // Taken branch from execute
        end else if (ctrl.regJmp) begin
            nextPc = rs + imm;
        end else if (ctrl.siic) begin
            nextPc  = siicVector;
            saveEpc = 1'b1;
        end else if (ctrl.rti) begin
            nextPc = epc;
        end else if (ctrl.halt) begin
            nextPc = pc;                  // Park on the HALT word
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= '0;
            epc <= '0;
        end else begin
            pc <= nextPc;
            if (saveEpc) begin
                epc <= pcPlus2;           // Resume after the SIIC
            end
        end
    end

endmodule

// ==== testbench/fetchProgram.hex ====
// One 16-bit instruction word per line in hex, word n sits at byte address 2n
// Handler code runs from 0002 to the RTI at 0036
0800 // NOP, reset entry
4225 // ADDI r1, r2, 5
4B9F // SUBI r4, r3, -1
55C3 // XORI r6, r5, 3
594A // ANDNI r2, r1, 10
A664 // ROLI r3, r6, 4
AFA1 // SLLI r5, r7, 1
B0E2 // RORI r7, r0, 2
BC10 // SRLI r0, r4, 16
6104 // BEQZ r1, 4
6AFC // BNEZ r2, -4
7310 // BLTZ r3, 16
7C02 // BGEZ r4, 2
82A1 // ST r5, r2, 1
8BC2 // LD r6, r3, 2
9D24 // STU r1, r5, 4
C67F // LBI r6, 127
93A5 // SLBI r3, 0xA5
C910 // BTR r4, r1
D275 // SLL r5, r2, r3
DCBA // XOR r6, r4, r5
E728 // SEQ r2, r7, r1
E8CC // SLT r3, r0, r6
F55C // SLE r7, r5, r2
FB84 // SCO r1, r3, r4
2010 // J 16
37F0 // JAL -16
1800 // RTI at 0036
2A08 // JR r2, 8 at 0038
3CF0 // JALR r4, -16 at 003A
3123 // JAL at 003C
0000 // HALT at 003E
1000 // SIIC at 0040
0800
0800
0800
0800
0800

// ==== testbench/fetchStageTb.sv ====
// Fetch stage testbench
`timescale 1ns/1ps

module fetchStageTb import fetchPkg::*; ();

    // Landmarks in the program image
    localparam logic [wordWidth-1:0] rtiAddr  = 16'h0036;
    localparam logic [wordWidth-1:0] jrAddr   = 16'h0038;
    localparam logic [wordWidth-1:0] jalrAddr = 16'h003A;
    localparam logic [wordWidth-1:0] jalAddr  = 16'h003C;
    localparam logic [wordWidth-1:0] haltAddr = 16'h003E;
    localparam logic [wordWidth-1:0] siicAddr = 16'h0040;

    logic                    clk;
    logic                    reset;
    logic [wordWidth-1:0]    brnchAddr;
    logic                    pcSel;
    logic [wordWidth-1:0]    rs;
    logic [wordWidth-1:0]    imm;
    logic                    hazNop;
    logic [wordWidth-1:0]    pc;
    instrT                   instr;
    ctrlT                    ctrl;
    logic [regAddrWidth-1:0] writeRegAddr;

    logic [wordWidth-1:0] image [romDepth];
    logic [wordWidth-1:0] modelPc;
    logic [wordWidth-1:0] modelEpc;
    integer               seed;

    fetchStage UUT (
        .clk          (clk),
        .reset        (reset),
        .brnchAddr    (brnchAddr),
        .pcSel        (pcSel),
        .rs           (rs),
        .imm          (imm),
        .hazNop       (hazNop),
        .pc           (pc),
        .instr        (instr),
        .ctrl         (ctrl),
        .writeRegAddr (writeRegAddr)
    );

    always #5 clk = ~clk;

    function automatic logic [wordWidth-1:0] fetchWord(logic [wordWidth-1:0] addr, logic bubble);
        if (bubble) begin
            return nopWord;
        end else begin
            return image[addr[romAddrWidth:1]];
        end
    endfunction

    // Reference control word built field by field from opcode groups
    function automatic ctrlT expectCtrl(logic [wordWidth-1:0] word);
        ctrlT   e;
        opcodeT op;
        logic   aluImm;
        logic   logicImm;
        logic   condBr;
        logic   rGroup;
        op       = opcodeT'(word[15:11]);
        e        = '0;
        aluImm   = 1'b0;
        logicImm = 1'b0;
        condBr   = 1'b0;
        rGroup   = 1'b0;
        case (op)
            ADDI, SUBI: aluImm = 1'b1;
            XORI, ANDNI, ROLI, SLLI, RORI, SRLI: logicImm = 1'b1;
            BEQZ, BNEZ, BLTZ, BGEZ: condBr = 1'b1;
            BTR, ROTR, ARITHR, SEQ, SLT, SLE, SCO: rGroup = 1'b1;
            default: ;
        endcase
        e.aluOp     = op;
        e.halt      = (op == HALT);
        e.siic      = (op == SIIC);
        e.rti       = (op == RTI);
        e.regJmp    = (op == JR) || (op == JALR);
        e.branch    = condBr || (op == J) || (op == JAL);
        e.memEnable = (op == ST) || (op == LD) || (op == STU);
        e.memWr     = (op == ST) || (op == STU);
        e.val2Reg   = (op == LD);
        e.regWrite  = aluImm || logicImm || rGroup || (op == LD) || (op == STU)
                      || (op == LBI) || (op == SLBI) || (op == JAL) || (op == JALR);
        e.aluSel    = aluImm || logicImm || e.regJmp || e.memEnable
                      || (op == LBI) || (op == SLBI);
        if ((op == J) || (op == JAL)) begin
            e.immSel = immSext11;
        end else if (e.regJmp || condBr || (op == LBI)) begin
            e.immSel = immSext8;
        end else if (aluImm || e.memEnable) begin
            e.immSel = immSext5;
        end else if (op == SLBI) begin
            e.immSel = immZext8;
        end else begin
            e.immSel = immZext5;
        end
        if ((op == JAL) || (op == JALR)) begin
            e.linkSel = linkPc;
        end else if (op == LBI) begin
            e.linkSel = linkImm;       // Immediate written directly
        end else begin
            e.linkSel = linkAlu;
        end
        return e;
    endfunction

    function automatic logic [regAddrWidth-1:0] expectDest(logic [wordWidth-1:0] word);
        logic [regAddrWidth-1:0] dest;
        case (opcodeT'(word[15:11]))
            LBI, SLBI, STU: dest = word[10:8];
            BTR, ROTR, ARITHR, SEQ, SLT, SLE, SCO: dest = word[4:2];
            JAL, JALR: dest = linkReg;
            default: dest = word[7:5];  // I1 layout rd
        endcase
        return dest;
    endfunction

    task automatic stopOnFailure();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [wordWidth-1:0] actual,
                             input logic [wordWidth-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkInstr(input instrT actual, input instrT expected);
        if (actual !== expected) begin
            $display("error at %0t: instr is %h, expected %h", $time, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkCtrl(input ctrlT actual, input ctrlT expected);
        if (actual !== expected) begin
            $display("error at %0t: ctrl is %h, expected %h", $time, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkReg(input logic [regAddrWidth-1:0] actual,
                            input logic [regAddrWidth-1:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: writeRegAddr is %h, expected %h", $time, actual, expected);
            stopOnFailure();
        end
    endtask

    // Model of the next-PC priority chain
    task automatic predictNext();
        ctrlT                 c;
        logic [wordWidth-1:0] plus2;
        c     = expectCtrl(fetchWord(modelPc, hazNop));
        plus2 = modelPc + 16'd2;
        if (pcSel) begin
            modelPc = brnchAddr;
        end else if (c.regJmp) begin
            modelPc = rs + imm;
        end else if (c.siic) begin
            modelEpc = plus2;
            modelPc  = siicVector;
        end else if (c.rti) begin
            modelPc = modelEpc;
        end else if (!c.halt) begin
            modelPc = plus2;
        end
    endtask

    task automatic stepAndCheck();
        predictNext();
        @(posedge clk);
        #1;
        checkWord("pc", pc, modelPc);
    endtask

    task automatic checkDecode();
        logic [wordWidth-1:0] word;
        word = fetchWord(modelPc, hazNop);
        #1;                            // Let the new inputs settle
        checkInstr(instr, instrT'(word));
        checkCtrl(ctrl, expectCtrl(word));
        checkReg(writeRegAddr, expectDest(word));
    endtask

    task automatic waitForPc(input logic [wordWidth-1:0] target, input int limit);
        int steps;
        steps = 0;
        while (pc !== target) begin
            if (steps >= limit) begin
                $display("Timeout: pc did not reach %h within %0d cycles", target, limit);
                stopOnFailure();
            end
            checkDecode();
            stepAndCheck();
            steps++;
        end
    endtask

    task automatic waitForHalt(input int limit);
        int steps;
        steps = 0;
        while (ctrl.halt !== 1'b1) begin
            if (steps >= limit) begin
                $display("Timeout: no HALT word was decoded within %0d cycles", limit);
                stopOnFailure();
            end
            checkDecode();
            stepAndCheck();
            steps++;
        end
    endtask

    task automatic applyReset();
        reset = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        reset    = 1'b0;
        modelPc  = '0;
        modelEpc = '0;
    endtask

    task automatic resetState();
        checkWord("pc", pc, 16'h0000);
        checkDecode();
        checkCtrl(ctrl, expectCtrl(nopWord));
    endtask

    task automatic sequentialDecode();
        logic [wordWidth-1:0] prevPc;
        int                   steps;
        steps = 0;
        while (pc !== rtiAddr) begin
            if (steps >= 40) begin
                $display("Timeout: straight-line code never reached the RTI word");
                stopOnFailure();
            end
            prevPc = pc;
            checkDecode();
            stepAndCheck();
            checkWord("pc", pc, prevPc + 16'd2);
            steps++;
        end
    endtask

    task automatic branchAndJump();
        logic [wordWidth-1:0] target;
        pcSel     = 1'b1;
        brnchAddr = jrAddr;
        stepAndCheck();
        checkWord("pc", pc, jrAddr);
        pcSel  = 1'b0;
        rs     = $random(seed);
        imm    = $random(seed);
        target = rs + imm;
        checkDecode();
        stepAndCheck();
        checkWord("pc", pc, target);
        pcSel     = 1'b1;                 // JALR also links to r7
        brnchAddr = jalrAddr;
        stepAndCheck();
        pcSel  = 1'b0;
        rs     = $random(seed);
        imm    = $random(seed);
        target = rs + imm;
        checkDecode();
        stepAndCheck();
        checkWord("pc", pc, target);
    endtask

    task automatic hazardBubble();
        logic [wordWidth-1:0] prevPc;
        pcSel     = 1'b1;
        brnchAddr = jalAddr;
        stepAndCheck();
        pcSel  = 1'b0;
        hazNop = 1'b1;
        repeat (2) begin                  // Cancels the JAL and then the HALT
            prevPc = pc;
            checkDecode();
            checkCtrl(ctrl, expectCtrl(nopWord));
            stepAndCheck();
            checkWord("pc", pc, prevPc + 16'd2);
        end
        hazNop = 1'b0;
    endtask

    task automatic haltHold();
        pcSel     = 1'b1;
        brnchAddr = jalAddr;
        stepAndCheck();
        pcSel = 1'b0;
        waitForHalt(8);
        checkWord("pc", pc, haltAddr);
        repeat (4) begin
            checkDecode();
            stepAndCheck();
            checkWord("pc", pc, haltAddr);
        end
    endtask

    task automatic exceptionReturn();
        pcSel     = 1'b1;
        brnchAddr = siicAddr;
        stepAndCheck();
        pcSel = 1'b0;
        checkDecode();
        stepAndCheck();
        checkWord("pc", pc, 16'h0002);  // Handler entry
        waitForPc(rtiAddr, 40);
        checkDecode();
        stepAndCheck();
        checkWord("pc", pc, siicAddr + 16'd2);
    endtask

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        brnchAddr = '0;
        pcSel     = 1'b0;
        rs        = '0;
        imm       = '0;
        hazNop    = 1'b0;
        seed      = 32'h4e81;
        $readmemh(romImage, image);
        applyReset();
        resetState();
        sequentialDecode();
        branchAndJump();
        hazardBubble();
        haltHold();
        exceptionReturn();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule
